/* inst_pkg.sv */
`default_nettype none

package inst_pkg;

  localparam int VADDR_W = 32;
  localparam int RNID_W  = 6;

  // Instruction classes seen by the ROB.
  typedef enum logic [2:0] {
    ALU    = 3'd0,
    LOAD   = 3'd1,
    STORE  = 3'd2,
    BRANCH = 3'd3,
    NOP    = 3'd4
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [4:0]  rd;       // Architectural destination.
    logic [15:0] imm_tag;  // Immediate or tracking tag.
  } inst_t;

endpackage

`default_nettype wire

/* rob_pkg.sv */
`default_nettype none

package rob_pkg;

  localparam int DISP_SIZE    = 2;
  localparam int CMT_ID_W     = 4;  // Up to 16 groups in flight.
  localparam int CMT_BUS_SIZE = 2;
  localparam int GRP_IDX_W    = (DISP_SIZE > 1) ? $clog2(DISP_SIZE) : 1;

  // Wishbone write data for one dispatch group.
  typedef struct packed {
    logic [inst_pkg::VADDR_W-1:1]                      pc_addr;
    logic [DISP_SIZE-1:0]                              grp_id;
    inst_pkg::inst_t [DISP_SIZE-1:0]                   inst;
    logic [DISP_SIZE-1:0]                              old_rd_valid;
    logic [DISP_SIZE-1:0][inst_pkg::RNID_W-1:0]        old_rd_rnid;
  } disp_grp_t;

  typedef struct packed {
    logic                 valid;
    logic [CMT_ID_W-1:0]  cmt_id;
    logic [DISP_SIZE-1:0] grp_id;  // One-hot member.
  } done_rpt_t;

  typedef struct packed {
    logic                         update;
    logic [CMT_ID_W-1:0]          cmt_id;
    logic [DISP_SIZE-1:0]         grp_id;
    logic [inst_pkg::VADDR_W-1:0] vaddr;
  } br_upd_t;

  typedef struct packed {
    logic [DISP_SIZE-1:0]                              upd_valid;
    logic [DISP_SIZE-1:0][inst_pkg::VADDR_W-1:0]       upd_br_vaddr;
  } br_info_t;

  typedef struct packed {
    logic [DISP_SIZE-1:0]                              grp_id;
    logic [inst_pkg::VADDR_W-1:1]                      pc_addr;
    inst_pkg::inst_t [DISP_SIZE-1:0]                   inst;
    logic [DISP_SIZE-1:0]                              done_grp_id;
    logic [DISP_SIZE-1:0]                              old_rd_valid;
    logic [DISP_SIZE-1:0][inst_pkg::RNID_W-1:0]        old_rd_rnid;
    br_info_t                                          br_upd_info;
  } rob_entry_t;

  typedef struct packed {
    logic [CMT_ID_W-1:0]                               cmt_id;
    logic [inst_pkg::VADDR_W-1:1]                      pc_addr;
    inst_pkg::inst_t [DISP_SIZE-1:0]                   inst;
    logic [DISP_SIZE-1:0]                              grp_id;
    logic [DISP_SIZE-1:0]                              old_rd_valid;
    logic [DISP_SIZE-1:0][inst_pkg::RNID_W-1:0]        old_rd_rnid;
    br_info_t                                          br_upd_info;
  } commit_t;

  // One-hot member bit to member index.
  function automatic logic [GRP_IDX_W-1:0] encode_grp_id(input logic [DISP_SIZE-1:0] grp_id);
    logic [GRP_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (grp_id[i]) begin
        idx = GRP_IDX_W'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

/* rob_dispatch.sv */
`default_nettype none

module rob_dispatch #(
  parameter int ROB_DEPTH = 8
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,
  input  wire logic                         i_wb_cyc,
  input  wire logic                         i_wb_stb,
  input  wire logic                         i_wb_we,
  input  wire rob_pkg::disp_grp_t           i_wb_dat,
  input  wire logic                         i_full,
  input  wire logic [rob_pkg::CMT_ID_W-1:0] i_tail_id,
  output logic                              o_wb_ack,
  output logic [rob_pkg::CMT_ID_W-1:0]      o_wb_dat,
  output logic                              o_load_valid,
  output rob_pkg::disp_grp_t                o_load_grp
);

  localparam int IDX_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;

  typedef enum logic {
    IDLE,
    ACK
  } state_t;

  state_t r_state;
  logic   w_strobe;
  logic   w_accept;

  assign w_strobe     = i_wb_cyc & i_wb_stb & (r_state == IDLE);
  assign w_accept     = w_strobe & (!i_wb_we | !i_full);  // Reads never stall.
  assign o_load_valid = w_strobe & i_wb_we & !i_full;
  assign o_load_grp   = i_wb_dat;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= IDLE;
      o_wb_ack <= 1'b0;
    end else begin
      case (r_state)
        IDLE: begin
          if (w_accept) begin
            r_state  <= ACK;
            o_wb_ack <= 1'b1;
          end
        end
        ACK: begin
          o_wb_ack <= 1'b0;  // Single-cycle ack.
          if (!(i_wb_cyc & i_wb_stb)) begin
            r_state <= IDLE;
          end
        end
        default: begin
          r_state  <= IDLE;
          o_wb_ack <= 1'b0;
        end
      endcase
    end
  end

  // Slot index of the new group, returned with the ack.
  always_ff @(posedge i_clk) begin
    if (o_load_valid) begin
      o_wb_dat <= rob_pkg::CMT_ID_W'(i_tail_id[IDX_W-1:0]);
    end
  end

endmodule

`default_nettype wire

/* rob_entry.sv */
`default_nettype none

module rob_entry (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,
  input  wire logic [rob_pkg::CMT_ID_W-1:0] i_cmt_id,
  input  wire logic                         i_load_valid,
  input  wire rob_pkg::disp_grp_t           i_load_grp,
  input  wire rob_pkg::done_rpt_t           i_done_rpt [rob_pkg::CMT_BUS_SIZE],
  input  wire rob_pkg::br_upd_t             i_br_upd,
  input  wire logic                         i_commit_finish,
  output rob_pkg::rob_entry_t               o_entry,
  output logic                              o_valid,
  output logic                              o_block_all_done
);

  logic                              r_valid;
  rob_pkg::rob_entry_t               r_entry;
  logic [rob_pkg::DISP_SIZE-1:0]     w_done_vld;
  logic                              w_br_hit;
  logic [rob_pkg::GRP_IDX_W-1:0]     w_br_idx;

  // Members reported done to this slot in this cycle.
  always_comb begin
    w_done_vld = '0;
    for (int c = 0; c < rob_pkg::CMT_BUS_SIZE; c++) begin
      if (i_done_rpt[c].valid && (i_done_rpt[c].cmt_id == i_cmt_id)) begin
        w_done_vld = w_done_vld | i_done_rpt[c].grp_id;
      end
    end
  end

  assign w_br_hit = i_br_upd.update & (i_br_upd.cmt_id == i_cmt_id);
  assign w_br_idx = rob_pkg::encode_grp_id(i_br_upd.grp_id);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_load_valid) begin
      r_valid <= 1'b1;
    end else if (o_block_all_done && i_commit_finish) begin
      r_valid <= 1'b0;  // Retired.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_entry.grp_id                <= i_load_grp.grp_id;
      r_entry.pc_addr               <= i_load_grp.pc_addr;
      r_entry.inst                  <= i_load_grp.inst;
      r_entry.old_rd_valid          <= i_load_grp.old_rd_valid;
      r_entry.old_rd_rnid           <= i_load_grp.old_rd_rnid;
      r_entry.done_grp_id           <= '0;
      r_entry.br_upd_info.upd_valid <= '0;
    end else if (r_valid) begin
      r_entry.done_grp_id <= r_entry.done_grp_id | w_done_vld;
      if (w_br_hit) begin
        r_entry.br_upd_info.upd_valid[w_br_idx]    <= 1'b1;
        r_entry.br_upd_info.upd_br_vaddr[w_br_idx] <= i_br_upd.vaddr;
      end
    end
  end

  assign o_entry          = r_entry;
  assign o_valid          = r_valid;
  assign o_block_all_done = r_valid & (r_entry.done_grp_id == r_entry.grp_id);

endmodule

`default_nettype wire

/* rob_buffer.sv */
`default_nettype none

module rob_buffer #(
  parameter int ROB_DEPTH = 8
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,
  input  wire logic                         i_load_valid,
  input  wire rob_pkg::disp_grp_t           i_load_grp,
  input  wire rob_pkg::done_rpt_t           i_done_rpt [rob_pkg::CMT_BUS_SIZE],
  input  wire rob_pkg::br_upd_t             i_br_upd,
  input  wire logic                         i_commit_finish,
  output logic                              o_full,
  output logic [rob_pkg::CMT_ID_W-1:0]      o_tail_id,
  output rob_pkg::rob_entry_t               o_head_entry,
  output logic [rob_pkg::CMT_ID_W-1:0]      o_head_id,
  output logic                              o_head_all_done
);

  localparam int IDX_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;

  logic [IDX_W-1:0]      r_tail;
  logic [IDX_W-1:0]      r_head;
  logic [IDX_W:0]        w_count;
  rob_pkg::rob_entry_t   w_entry [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]  w_valid;
  logic [ROB_DEPTH-1:0]  w_all_done;

  for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entry
    rob_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_cmt_id         (rob_pkg::CMT_ID_W'(i)),
      .i_load_valid     (i_load_valid && (r_tail == IDX_W'(i))),
      .i_load_grp       (i_load_grp),
      .i_done_rpt       (i_done_rpt),
      .i_br_upd         (i_br_upd),
      .i_commit_finish  (i_commit_finish && (r_head == IDX_W'(i))),
      .o_entry          (w_entry[i]),
      .o_valid          (w_valid[i]),
      .o_block_all_done (w_all_done[i])
    );
  end

  // Occupied slots.
  always_comb begin
    w_count = '0;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      w_count = w_count + (IDX_W + 1)'(w_valid[i]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
      r_head <= '0;
    end else begin
      if (i_load_valid) begin
        r_tail <= (r_tail == IDX_W'(ROB_DEPTH - 1)) ? '0 : r_tail + 1'b1;
      end
      if (i_commit_finish) begin
        r_head <= (r_head == IDX_W'(ROB_DEPTH - 1)) ? '0 : r_head + 1'b1;
      end
    end
  end

  assign o_full          = (w_count == (IDX_W + 1)'(ROB_DEPTH));
  assign o_tail_id       = rob_pkg::CMT_ID_W'(r_tail);
  assign o_head_id       = rob_pkg::CMT_ID_W'(r_head);
  assign o_head_entry    = w_entry[r_head];
  assign o_head_all_done = w_all_done[r_head];

endmodule

`default_nettype wire

/* rob_commit.sv */
`default_nettype none

module rob_commit (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,
  input  wire rob_pkg::rob_entry_t          i_head_entry,
  input  wire logic [rob_pkg::CMT_ID_W-1:0] i_head_id,
  input  wire logic                         i_head_all_done,
  input  wire logic                         i_commit_stall,
  output logic                              o_commit_finish,
  output logic                              o_commit_valid,
  output rob_pkg::commit_t                  o_commit
);

  rob_pkg::commit_t w_record;

  assign o_commit_finish = i_head_all_done & !i_commit_stall;

  always_comb begin
    w_record.cmt_id       = i_head_id;
    w_record.pc_addr      = i_head_entry.pc_addr;
    w_record.inst         = i_head_entry.inst;
    w_record.grp_id       = i_head_entry.grp_id;
    // Only real members free their old rename id.
    w_record.old_rd_valid = i_head_entry.old_rd_valid & i_head_entry.grp_id;
    w_record.old_rd_rnid  = i_head_entry.old_rd_rnid;
    w_record.br_upd_info  = i_head_entry.br_upd_info;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= o_commit_finish;  // One pulse per group.
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_commit_finish) begin
      o_commit <= w_record;
    end
  end

endmodule

`default_nettype wire

/* rob_top.sv */
`default_nettype none

module rob_top #(
  parameter int ROB_DEPTH = 8
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_reset_n,
  input  wire logic                         i_wb_cyc,
  input  wire logic                         i_wb_stb,
  input  wire logic                         i_wb_we,
  input  wire rob_pkg::disp_grp_t           i_wb_dat,
  output logic                              o_wb_ack,
  output logic [rob_pkg::CMT_ID_W-1:0]      o_wb_dat,
  input  wire rob_pkg::done_rpt_t           i_done_rpt [rob_pkg::CMT_BUS_SIZE],
  input  wire rob_pkg::br_upd_t             i_br_upd,
  input  wire logic                         i_commit_stall,
  output logic                              o_commit_valid,
  output rob_pkg::commit_t                  o_commit
);

  logic                          w_load_valid;
  rob_pkg::disp_grp_t            w_load_grp;
  logic                          w_full;
  logic [rob_pkg::CMT_ID_W-1:0]  w_tail_id;
  rob_pkg::rob_entry_t           w_head_entry;
  logic [rob_pkg::CMT_ID_W-1:0]  w_head_id;
  logic                          w_head_all_done;
  logic                          w_commit_finish;

  rob_dispatch #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_dat     (i_wb_dat),
    .i_full       (w_full),
    .i_tail_id    (w_tail_id),
    .o_wb_ack     (o_wb_ack),
    .o_wb_dat     (o_wb_dat),
    .o_load_valid (w_load_valid),
    .o_load_grp   (w_load_grp)
  );

  rob_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_buffer (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_load_valid    (w_load_valid),
    .i_load_grp      (w_load_grp),
    .i_done_rpt      (i_done_rpt),
    .i_br_upd        (i_br_upd),
    .i_commit_finish (w_commit_finish),
    .o_full          (w_full),
    .o_tail_id       (w_tail_id),
    .o_head_entry    (w_head_entry),
    .o_head_id       (w_head_id),
    .o_head_all_done (w_head_all_done)
  );

  rob_commit u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_head_entry    (w_head_entry),
    .i_head_id       (w_head_id),
    .i_head_all_done (w_head_all_done),
    .i_commit_stall  (i_commit_stall),
    .o_commit_finish (w_commit_finish),
    .o_commit_valid  (o_commit_valid),
    .o_commit        (o_commit)
  );

endmodule

`default_nettype wire

/* tb_rob.sv */
`default_nettype none

module tb_rob;

  localparam int DEPTH    = 4;
  localparam int NUM_ROWS = 12;
  localparam int PORT_W   = $clog2(rob_pkg::CMT_BUS_SIZE);

  typedef struct packed {
    logic [inst_pkg::VADDR_W-1:1]                            pc;
    logic [rob_pkg::DISP_SIZE-1:0]                           grp;
    inst_pkg::inst_t [rob_pkg::DISP_SIZE-1:0]                inst;
    logic [rob_pkg::DISP_SIZE-1:0]                           old_v;
    logic [rob_pkg::DISP_SIZE-1:0][inst_pkg::RNID_W-1:0]     old_rn;
    logic [rob_pkg::DISP_SIZE-1:0]                           br_grp;
    logic [inst_pkg::VADDR_W-1:0]                            br_vaddr;
    logic                                                    drain;  // Complete all pending groups.
    logic [3:0]                                              stall;
    logic                                                    block;  // Write meets a full buffer.
  } row_t;

  logic                          clk;
  logic                          reset_n;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  rob_pkg::disp_grp_t            wb_dat;
  logic                          wb_ack;
  logic [rob_pkg::CMT_ID_W-1:0]  wb_dat_o;
  rob_pkg::done_rpt_t            done_rpt [rob_pkg::CMT_BUS_SIZE];
  rob_pkg::br_upd_t              br_upd;
  logic                          commit_stall;
  logic                          commit_valid;
  rob_pkg::commit_t              commit;

  row_t                          rows [NUM_ROWS];
  rob_pkg::commit_t              exp_q [$];
  logic [rob_pkg::CMT_ID_W-1:0]  pend_q [$];
  logic [1:0]                    rem_mask [2**rob_pkg::CMT_ID_W];  // Members not yet reported.

  rob_top #(.ROB_DEPTH(DEPTH)) DUT (
    .i_clk(clk),
    .i_reset_n(reset_n),
    .i_wb_cyc(wb_cyc),
    .i_wb_stb(wb_stb),
    .i_wb_we(wb_we),
    .i_wb_dat(wb_dat),
    .o_wb_ack(wb_ack),
    .o_wb_dat(wb_dat_o),
    .i_done_rpt(done_rpt),
    .i_br_upd(br_upd),
    .i_commit_stall(commit_stall),
    .o_commit_valid(commit_valid),
    .o_commit(commit)
  );

  always #2 clk = ~clk;

  function automatic row_t make_row(input logic [31:0] pc, input logic [1:0] grp,
      input inst_pkg::op_t op0, input inst_pkg::op_t op1, input logic [1:0] old_v,
      input logic [1:0] br_grp, input logic drain, input logic [3:0] stall, input logic block);
    row_t r;
    r.pc        = pc[31:1];
    r.grp       = grp;
    r.inst[0]   = '{op: op0, rd: pc[6:2], imm_tag: pc[15:0]};
    r.inst[1]   = '{op: op1, rd: pc[11:7], imm_tag: ~pc[15:0]};
    r.old_v     = old_v;
    r.old_rn[0] = pc[7:2];
    r.old_rn[1] = pc[13:8];
    r.br_grp    = br_grp;
    r.br_vaddr  = pc + 32'h40;
    r.drain     = drain;
    r.stall     = stall;
    r.block     = block;
    return r;
  endfunction

  // Commit record as the group should retire it.
  function automatic rob_pkg::commit_t expect_commit(input row_t r, input logic [3:0] id);
    rob_pkg::commit_t c;
    c.cmt_id                = id;
    c.pc_addr               = r.pc;
    c.inst                  = r.inst;
    c.grp_id                = r.grp;
    c.old_rd_valid          = r.old_v & r.grp;
    c.old_rd_rnid           = r.old_rn;
    c.br_upd_info.upd_valid = r.br_grp;
    for (int m = 0; m < rob_pkg::DISP_SIZE; m++) begin
      c.br_upd_info.upd_br_vaddr[m] = r.br_grp[m] ? r.br_vaddr : '0;
    end
    return c;
  endfunction

  task automatic compare_values(input string what, input logic [255:0] got,
      input logic [255:0] want);
    if (got !== want) begin
      $display("** Error at time %0t: %s, got %0h, expected %0h", $time, what, got, want);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string which);
    $display("Timeout: gave up waiting for %s at time %0t", which, $time);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic wait_ack(input int limit);
    int n;
    n = 0;
    while (!wb_ack) begin
      @(negedge clk);
      n++;
      if (n > limit) report_timeout("the Wishbone ack");
    end
  endtask

  task automatic wait_queue(input int left, input string which, input int limit);
    int n;
    n = 0;
    while (exp_q.size() > left) begin
      @(negedge clk);
      n++;
      if (n > limit) report_timeout(which);
    end
  endtask

  task automatic send_report(input logic [3:0] id, input logic [1:0] bit_oh);
    logic [PORT_W-1:0] port;
    port = PORT_W'($urandom % rob_pkg::CMT_BUS_SIZE);
    done_rpt[port] = '{valid: 1'b1, cmt_id: id, grp_id: bit_oh};
    rem_mask[id] = rem_mask[id] & ~bit_oh;
    @(negedge clk);
    done_rpt[port] = '0;
  endtask

  // Head finishes one member at a time; it must hold until the last one.
  task automatic release_head();
    logic [3:0] id;
    id = pend_q.pop_front();
    for (int m = 0; m < rob_pkg::DISP_SIZE; m++) begin
      if (rem_mask[id][m]) begin
        send_report(id, 2'(1 << m));
        if (rem_mask[id] != 2'b00) begin
          repeat (4) begin
            @(negedge clk);
            compare_values("commit of a partly done group", 256'(commit_valid), 256'(1'b0));
            compare_values("ack with a full buffer", 256'(wb_ack), 256'(1'b0));
          end
        end
      end
    end
  endtask

  task automatic write_group(input row_t r, input logic [3:0] exp_id);
    if (r.block) wait_queue(pend_q.size(), "earlier commits", 40);
    wb_dat.pc_addr      = r.pc;
    wb_dat.grp_id       = r.grp;
    wb_dat.inst         = r.inst;
    wb_dat.old_rd_valid = r.old_v;
    wb_dat.old_rd_rnid  = r.old_rn;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b1;
    if (r.block) begin
      repeat (6) begin
        @(negedge clk);
        compare_values("ack with a full buffer", 256'(wb_ack), 256'(1'b0));
      end
      release_head();
    end
    wait_ack(20);
    compare_values("commit id on dat_o", 256'(wb_dat_o), 256'(exp_id));
    exp_q.push_back(expect_commit(r, exp_id));
    rem_mask[exp_id] = r.grp;
    pend_q.push_back(exp_id);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (r.br_grp != 2'b00) br_upd = '{update: 1'b1, cmt_id: exp_id, grp_id: r.br_grp,
                                      vaddr: r.br_vaddr};
    @(negedge clk);
    br_upd = '0;
  endtask

  // Reports for every pending member, shuffled and spaced at random.
  task automatic drain_pending(input logic [3:0] stall);
    logic [3:0] ids [$];
    logic [1:0] bits [$];
    logic [3:0] tid;
    logic [1:0] tbit;
    int         j;
    wait_queue(pend_q.size(), "earlier commits", 40);
    for (int p = 0; p < pend_q.size(); p++) begin
      for (int m = 0; m < rob_pkg::DISP_SIZE; m++) begin
        if (rem_mask[pend_q[p]][m]) begin
          ids.push_back(pend_q[p]);
          bits.push_back(2'(1 << m));
        end
      end
    end
    for (int i = ids.size() - 1; i > 0; i--) begin
      j = $urandom % (i + 1);
      tid = ids[i];
      ids[i] = ids[j];
      ids[j] = tid;
      tbit = bits[i];
      bits[i] = bits[j];
      bits[j] = tbit;
    end
    commit_stall = (stall != 4'd0);
    for (int i = 0; i < ids.size(); i++) begin
      send_report(ids[i], bits[i]);
      if (commit_stall) compare_values("commit while stalled", 256'(commit_valid), 256'(1'b0));
      repeat ($urandom % 3) @(negedge clk);
    end
    repeat (stall) begin
      @(negedge clk);
      compare_values("commit while stalled", 256'(commit_valid), 256'(1'b0));
    end
    commit_stall = 1'b0;
    pend_q.delete();
  endtask

  always @(negedge clk) begin : check_commits
    rob_pkg::commit_t got;
    rob_pkg::commit_t want;
    if (reset_n && commit_valid) begin
      got = commit;
      for (int m = 0; m < rob_pkg::DISP_SIZE; m++) begin
        if (!got.br_upd_info.upd_valid[m]) got.br_upd_info.upd_br_vaddr[m] = '0;
      end
      if (exp_q.size() == 0) begin
        compare_values("commit with none outstanding", 256'(1'b1), 256'(1'b0));
      end else begin
        want = exp_q.pop_front();
        compare_values("commit record", 256'(got), 256'(want));
        compare_values("members left unreported", 256'(rem_mask[want.cmt_id]), 256'(2'b00));
      end
    end
  end

  initial begin
    void'($urandom(71));
    clk = 1'b0;
    reset_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_dat = '0;
    br_upd = '0;
    commit_stall = 1'b0;
    for (int p = 0; p < rob_pkg::CMT_BUS_SIZE; p++) done_rpt[p] = '0;
    for (int k = 0; k < 2**rob_pkg::CMT_ID_W; k++) rem_mask[k] = 2'b00;
    rows[0]  = make_row(32'h1000, 2'b11, inst_pkg::ALU, inst_pkg::LOAD, 2'b11, 2'b00, 1, 0, 0);
    rows[1]  = make_row(32'h1008, 2'b01, inst_pkg::BRANCH, inst_pkg::NOP, 2'b11, 2'b01, 0, 0, 0);
    rows[2]  = make_row(32'h1010, 2'b11, inst_pkg::STORE, inst_pkg::BRANCH, 2'b10, 2'b10, 0, 0, 0);
    rows[3]  = make_row(32'h1018, 2'b10, inst_pkg::NOP, inst_pkg::ALU, 2'b11, 2'b00, 1, 0, 0);
    rows[4]  = make_row(32'h2000, 2'b11, inst_pkg::LOAD, inst_pkg::ALU, 2'b01, 2'b00, 0, 0, 0);
    rows[5]  = make_row(32'h2008, 2'b11, inst_pkg::ALU, inst_pkg::ALU, 2'b11, 2'b00, 0, 0, 0);
    rows[6]  = make_row(32'h2010, 2'b01, inst_pkg::STORE, inst_pkg::NOP, 2'b00, 2'b00, 0, 0, 0);
    rows[7]  = make_row(32'h2018, 2'b11, inst_pkg::ALU, inst_pkg::BRANCH, 2'b11, 2'b10, 0, 0, 0);
    rows[8]  = make_row(32'h2020, 2'b11, inst_pkg::LOAD, inst_pkg::LOAD, 2'b11, 2'b00, 1, 0, 1);
    rows[9]  = make_row(32'h3000, 2'b11, inst_pkg::ALU, inst_pkg::STORE, 2'b10, 2'b00, 0, 0, 0);
    rows[10] = make_row(32'h3008, 2'b01, inst_pkg::BRANCH, inst_pkg::NOP, 2'b01, 2'b01, 0, 0, 0);
    rows[11] = make_row(32'h3010, 2'b11, inst_pkg::ALU, inst_pkg::ALU, 2'b11, 2'b10, 1, 8, 0);
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      compare_values("ack after reset", 256'(wb_ack), 256'(1'b0));
      compare_values("commit valid after reset", 256'(commit_valid), 256'(1'b0));
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      write_group(rows[i], 4'(i % DEPTH));  // Slots are handed out in ring order.
      if (rows[i].drain) drain_pending(rows[i].stall);
    end
    wait_queue(0, "the final commits", 60);
    repeat (5) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
inst_pkg.sv
rob_pkg.sv
rob_dispatch.sv
rob_entry.sv
rob_buffer.sv
rob_commit.sv
rob_top.sv
tb_rob.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
